/* include/net_params.svh */
`ifndef NET_PARAMS_SVH
`define NET_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Network dimensions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NET_DATA_WIDTH 8    // Activations, weights, biases and sums
`define NET_FEATURES   30   // Input vector length
`define NET_HIDDEN     4    // Hidden layer neurons
`define NET_OUTPUTS    2    // Output layer neurons

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Three registers per neuron layer plus one in the class selector
`define NET_LATENCY    7

`endif

/* include/net_weights.svh */
`ifndef NET_WEIGHTS_SVH
`define NET_WEIGHTS_SVH

// Each table is listed from the highest input down to input 0,
// so input 0 sits in the low byte

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hidden layer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define HIDDEN_W0 { \
	8'hF4, 8'hF0, 8'hCD, 8'hC8, 8'h0B, 8'h17, 8'hED, 8'h07, 8'h0F, 8'hD7, \
	8'hD7, 8'hEC, 8'hE1, 8'hE3, 8'hC0, 8'h16, 8'hF9, 8'h00, 8'hFF, 8'hE8, \
	8'hFF, 8'hEC, 8'hFC, 8'hEC, 8'h01, 8'hFE, 8'hF3, 8'h02, 8'h07, 8'hC4}
`define HIDDEN_B0 8'hF6

`define HIDDEN_W1 { \
	8'h12, 8'h05, 8'hF8, 8'h03, 8'h1A, 8'hE2, 8'h09, 8'hFD, 8'h04, 8'h11, \
	8'hF1, 8'h0C, 8'h02, 8'hE7, 8'h08, 8'hFA, 8'h13, 8'h06, 8'hEE, 8'h01, \
	8'h0D, 8'hF5, 8'h07, 8'h19, 8'hFC, 8'h0A, 8'hE9, 8'h03, 8'h16, 8'hF2}
`define HIDDEN_B1 8'h0C

`define HIDDEN_W2 { \
	8'h21, 8'hF6, 8'h0E, 8'h04, 8'hDC, 8'h07, 8'hFF, 8'h15, 8'hEB, 8'h02, \
	8'h09, 8'hF3, 8'h1C, 8'h05, 8'hE0, 8'h0B, 8'h03, 8'hF8, 8'h12, 8'hEA, \
	8'h06, 8'h1E, 8'hF9, 8'h0D, 8'h02, 8'hE5, 8'h17, 8'hFB, 8'h08, 8'h10}
`define HIDDEN_B2 8'h23

`define HIDDEN_W3 { \
	8'hFB, 8'h0A, 8'h13, 8'hEE, 8'h06, 8'h19, 8'hF4, 8'h02, 8'h0F, 8'hE3, \
	8'h14, 8'h07, 8'hF0, 8'h1B, 8'h03, 8'hED, 8'h0C, 8'h05, 8'hF7, 8'h18, \
	8'hE6, 8'h09, 8'h01, 8'h12, 8'hF2, 8'h0E, 8'h04, 8'hFD, 8'h1D, 8'hE8}
`define HIDDEN_B3 8'h05

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output layer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define OUT_W0 {8'h03, 8'hFE, 8'h05, 8'h02}
`define OUT_B0 8'h04

`define OUT_W1 {8'hFD, 8'h04, 8'h01, 8'h06}
`define OUT_B1 8'h02

`endif

/* rtl/net_pkg.sv */
`include "net_params.svh"

package net_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scalar types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [`NET_DATA_WIDTH-1:0] activation_t;

	// Wide enough to name any output neuron
	typedef logic [$clog2(`NET_OUTPUTS)-1:0] classIdx_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Layer vectors
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One sample presented to the network, feature 0 in the low byte
	typedef struct packed
	{
		activation_t [`NET_FEATURES-1:0] feature;
	} featureVec_t;

	typedef activation_t [`NET_HIDDEN-1:0] hiddenVec_t;    // Hidden layer activations
	typedef activation_t [`NET_OUTPUTS-1:0] scoreVec_t;    // Output layer scores

endpackage

/* rtl/neuronNode.sv */
`include "net_params.svh"

module neuronNode import net_pkg::*;
#(
	parameter int NumInputs = `NET_FEATURES,
	parameter logic [NumInputs*`NET_DATA_WIDTH-1:0] Weights = '0,
	parameter activation_t Bias = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t [NumInputs-1:0] inputs,
	output activation_t activation
);

	localparam int Width = `NET_DATA_WIDTH;

	activation_t [NumInputs-1:0] inputReg;    // Captured inputs
	activation_t [NumInputs-1:0] products;
	activation_t sumNext;
	activation_t sumReg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1, input capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
			inputReg <= '0;
		else
			inputReg <= inputs;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2, weighted sum
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < NumInputs; i++)
	begin : genProduct
		localparam activation_t Weight = Weights[i*Width +: Width];

		// Low byte of the signed product
		assign products[i] = activation_t'(inputReg[i] * Weight);
	end

	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + products[i];    // Wraps modulo 256
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			sumReg <= '0;
		else
			sumReg <= sumNext;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 3, ReLU output
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
			activation <= '0;
		else if (sumReg[Width-1])
			activation <= '0;    // Negative sum clamps to zero
		else
			activation <= sumReg;
	end

endmodule

/* rtl/classSelect.sv */
`include "net_params.svh"

module classSelect import net_pkg::*;
(
	input logic clk,
	input logic reset,
	input scoreVec_t scores,
	output classIdx_t classIdx
);

	classIdx_t bestIdx;
	activation_t bestScore;

	// Scores come out of a ReLU so they are never negative,
	// an unsigned compare is enough
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int i = 1; i < `NET_OUTPUTS; i++)
		begin
			if ($unsigned(scores[i]) > $unsigned(bestScore))    // Ties keep the lower index
			begin
				bestIdx = classIdx_t'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			classIdx <= '0;
		else
			classIdx <= bestIdx;
	end

endmodule

/* rtl/netTop.sv */
`include "net_params.svh"
`include "net_weights.svh"

module netTop import net_pkg::*;
(
	input logic clk,
	input logic reset,
	input featureVec_t features,
	output hiddenVec_t hidden,
	output scoreVec_t scores,
	output classIdx_t classIdx
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Hidden layer, all features to every neuron
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	neuronNode #(
		.NumInputs(`NET_FEATURES),
		.Weights(`HIDDEN_W0),
		.Bias(`HIDDEN_B0)
	) hiddenNode0 (
		.clk(clk),
		.reset(reset),
		.inputs(features.feature),
		.activation(hidden[0])
	);

	neuronNode #(
		.NumInputs(`NET_FEATURES),
		.Weights(`HIDDEN_W1),
		.Bias(`HIDDEN_B1)
	) hiddenNode1 (
		.clk(clk),
		.reset(reset),
		.inputs(features.feature),
		.activation(hidden[1])
	);

	neuronNode #(
		.NumInputs(`NET_FEATURES),
		.Weights(`HIDDEN_W2),
		.Bias(`HIDDEN_B2)
	) hiddenNode2 (
		.clk(clk),
		.reset(reset),
		.inputs(features.feature),
		.activation(hidden[2])
	);

	neuronNode #(
		.NumInputs(`NET_FEATURES),
		.Weights(`HIDDEN_W3),
		.Bias(`HIDDEN_B3)
	) hiddenNode3 (
		.clk(clk),
		.reset(reset),
		.inputs(features.feature),
		.activation(hidden[3])
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output layer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	neuronNode #(
		.NumInputs(`NET_HIDDEN),
		.Weights(`OUT_W0),
		.Bias(`OUT_B0)
	) outNode0 (
		.clk(clk),
		.reset(reset),
		.inputs(hidden),
		.activation(scores[0])
	);

	neuronNode #(
		.NumInputs(`NET_HIDDEN),
		.Weights(`OUT_W1),
		.Bias(`OUT_B1)
	) outNode1 (
		.clk(clk),
		.reset(reset),
		.inputs(hidden),
		.activation(scores[1])
	);

	// Winning class, one clock behind the scores
	classSelect classSel (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIdx(classIdx)
	);

endmodule

/* tb/netTop_chk.sv */
`include "net_params.svh"

module netTop_chk import net_pkg::*;
(
	input logic clk,
	input logic reset,
	input hiddenVec_t hidden,
	input scoreVec_t scores,
	input classIdx_t classIdx
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;    // Failed assertion count

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ReLU outputs never go negative
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < `NET_HIDDEN; i++)
	begin : genHiddenSign
		hiddenNonNegative: assert property (@(posedge clk) disable iff (reset)
			!hidden[i][`NET_DATA_WIDTH-1])
			else
			begin
				failCount++;
				$error("Hidden lane %0d has its sign bit set", i);
			end
	end

	for (genvar i = 0; i < `NET_OUTPUTS; i++)
	begin : genScoreSign
		scoreNonNegative: assert property (@(posedge clk) disable iff (reset)
			!scores[i][`NET_DATA_WIDTH-1])
			else
			begin
				failCount++;
				$error("Score lane %0d has its sign bit set", i);
			end
	end

	// Argmax of the scores one clock earlier with ties to class 0
	classFollowsScores: assert property (@(posedge clk) disable iff (reset)
		classIdx == (($unsigned($past(scores[1])) > $unsigned($past(scores[0]))) ? 1'b1 : 1'b0))
		else
		begin
			failCount++;
			$error("classIdx does not match the previous scores");
		end

endmodule

bind netTop netTop_chk i_netTopChk (
	.clk(clk),
	.reset(reset),
	.hidden(hidden),
	.scores(scores),
	.classIdx(classIdx)
);

/* tb/tb_netTop.sv */
`include "net_params.svh"
`include "net_weights.svh"

module tb_netTop import net_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int W = `NET_DATA_WIDTH;
	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 8;
	localparam int StreamLength = 50;
	localparam int CheckCycles = 8;    // Drive plus the checks at 3, 6 and 7 clocks
	localparam int OneHotRuns = 12;
	localparam int TestCycles = ResetCycles + 2 + CheckCycles * (1 + OneHotRuns + 4 + 4)
		+ StreamLength + `NET_LATENCY;
	localparam int TimeoutNs = (TestCycles + 100) * ClockPeriod;

	logic clk;
	logic reset;
	featureVec_t features;
	hiddenVec_t hidden;
	scoreVec_t scores;
	classIdx_t classIdx;

	int errorCount = 0;
	logic [31:0] rngState = 32'h81ae;

	netTop i_netTop (
		.clk(clk),
		.reset(reset),
		.features(features),
		.hidden(hidden),
		.scores(scores),
		.classIdx(classIdx)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Bias plus the low byte of every product modulo 256
	function automatic activation_t neuronSum(input logic [`NET_FEATURES*W-1:0] ins,
		input logic [`NET_FEATURES*W-1:0] weights, input activation_t bias, input int count);
		logic [W-1:0] acc;
		logic signed [2*W-1:0] prod;
		acc = bias;
		for (int i = 0; i < count; i++)
		begin
			prod = $signed(ins[i*W +: W]) * $signed(weights[i*W +: W]);
			acc = acc + prod[W-1:0];
		end
		return acc;
	endfunction

	function automatic activation_t relu(input activation_t s);
		return s[W-1] ? '0 : s;
	endfunction

	function automatic activation_t hiddenSum(input featureVec_t f, input int lane);
		case (lane)
			0: return neuronSum(f, `HIDDEN_W0, `HIDDEN_B0, `NET_FEATURES);
			1: return neuronSum(f, `HIDDEN_W1, `HIDDEN_B1, `NET_FEATURES);
			2: return neuronSum(f, `HIDDEN_W2, `HIDDEN_B2, `NET_FEATURES);
			default: return neuronSum(f, `HIDDEN_W3, `HIDDEN_B3, `NET_FEATURES);
		endcase
	endfunction

	function automatic hiddenVec_t firstLayer(input featureVec_t f);
		hiddenVec_t h;
		for (int i = 0; i < `NET_HIDDEN; i++)
			h[i] = relu(hiddenSum(f, i));
		return h;
	endfunction

	function automatic scoreVec_t secondLayer(input hiddenVec_t h);
		scoreVec_t s;
		s[0] = relu(neuronSum(h, `OUT_W0, `OUT_B0, `NET_HIDDEN));
		s[1] = relu(neuronSum(h, `OUT_W1, `OUT_B1, `NET_HIDDEN));
		return s;
	endfunction

	function automatic classIdx_t argmaxClass(input scoreVec_t s);
		return ($unsigned(s[1]) > $unsigned(s[0])) ? 1'b1 : 1'b0;    // Tie goes to class 0
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Four features per draw
	function featureVec_t randomFeatures();
		featureVec_t f;
		for (int i = 0; i < `NET_FEATURES; i++)
		begin
			if (i % 4 == 0)
				rngState = xorshift(rngState);
			f.feature[i] = rngState[(i % 4)*W +: W];
		end
		return f;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checking helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic checkValue(input string testName, input string signalName,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("FAILED %s %s expected %h actual %h", testName, signalName, expected, actual);
		end
	endtask

	// Features stay put afterwards so every stage settles on this vector
	task automatic applyAndCheck(input string testName, input featureVec_t f);
		hiddenVec_t expHidden;
		scoreVec_t expScores;
		expHidden = firstLayer(f);
		expScores = secondLayer(expHidden);
		@(posedge clk);
		features <= f;
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkValue(testName, "hidden", expHidden, hidden);
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkValue(testName, "scores", expScores, scores);
		@(posedge clk);
		@(negedge clk);
		checkValue(testName, "classIdx", argmaxClass(expScores), classIdx);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic resetClears();
		for (int i = 0; i < ResetCycles; i++)
		begin
			@(posedge clk);
			if (i == ResetCycles - 1)
				reset <= 1'b0;
			@(negedge clk);
			checkValue("reset", "hidden", '0, hidden);
			checkValue("reset", "scores", '0, scores);
			checkValue("reset", "classIdx", '0, classIdx);
		end
		@(posedge clk);    // First clock out of reset
		@(negedge clk);
		checkValue("afterReset", "hidden", '0, hidden);
		checkValue("afterReset", "scores", '0, scores);
		checkValue("afterReset", "classIdx", '0, classIdx);
	endtask

	task automatic zeroFeatureVector();
		hiddenVec_t biasOnly;
		biasOnly[0] = `HIDDEN_B0;
		biasOnly[1] = `HIDDEN_B1;
		biasOnly[2] = `HIDDEN_B2;
		biasOnly[3] = `HIDDEN_B3;
		applyAndCheck("zeroFeatures", '0);
		for (int i = 0; i < `NET_HIDDEN; i++)
			checkValue("zeroFeatures", "hidden bias lane", relu(biasOnly[i]), hidden[i]);
	endtask

	task automatic oneHotFeatures();
		activation_t values[4] = '{8'h01, 8'h05, 8'h80, 8'h7F};
		int positions[3] = '{0, 13, 29};
		featureVec_t f;
		foreach (positions[p])
		begin
			foreach (values[v])
			begin
				f = '0;
				f.feature[positions[p]] = values[v];
				applyAndCheck($sformatf("oneHot[%0d]=%h", positions[p], values[v]), f);
			end
		end
	endtask

	task automatic negativeHiddenSums();
		featureVec_t f;
		int tries;
		bit found;
		for (int lane = 0; lane < `NET_HIDDEN; lane++)
		begin
			found = 1'b0;
			tries = 0;
			while (!found && tries < 200)
			begin
				f = randomFeatures();
				found = hiddenSum(f, lane) >= 0 ? 1'b0 : 1'b1;
				tries++;
			end
			if (!found)
			begin
				errorCount++;
				$display("No vector with a negative sum was found for hidden neuron %0d", lane);
			end
			else
			begin
				applyAndCheck("negativeSums", f);
				checkValue("negativeSums", "clamped hidden lane", '0, hidden[lane]);
			end
		end
	endtask

	task automatic streamVectors();
		featureVec_t vecs[StreamLength];
		hiddenVec_t expHidden[StreamLength];
		scoreVec_t expScores[StreamLength];
		for (int i = 0; i < StreamLength; i++)
		begin
			vecs[i] = randomFeatures();
			expHidden[i] = firstLayer(vecs[i]);
			expScores[i] = secondLayer(expHidden[i]);
		end
		for (int j = 0; j < StreamLength + `NET_LATENCY; j++)
		begin
			@(posedge clk);
			if (j < StreamLength)
				features <= vecs[j];
			@(negedge clk);
			if (j >= 3 && j - 3 < StreamLength)
				checkValue($sformatf("streaming[%0d]", j - 3), "hidden", expHidden[j-3], hidden);
			if (j >= 6 && j - 6 < StreamLength)
				checkValue($sformatf("streaming[%0d]", j - 6), "scores", expScores[j-6], scores);
			if (j >= `NET_LATENCY && j - `NET_LATENCY < StreamLength)
				checkValue($sformatf("streaming[%0d]", j - `NET_LATENCY), "classIdx",
					argmaxClass(expScores[j-`NET_LATENCY]), classIdx);
		end
	endtask

	task automatic classTieBreak();
		featureVec_t f;
		scoreVec_t s;
		int tries;
		int hits;
		tries = 0;
		do
		begin
			f = randomFeatures();
			s = secondLayer(firstLayer(f));
			tries++;
		end
		while (s[0] != s[1] && tries < 2000);
		if (s[0] != s[1])
		begin
			errorCount++;
			$display("No vector with equal scores was found for the tie test");
		end
		else
		begin
			applyAndCheck("classTie", f);
			checkValue("classTie", "tie classIdx", '0, classIdx);
		end
		hits = 0;
		tries = 0;
		while (hits < 3 && tries < 2000)
		begin
			f = randomFeatures();
			s = secondLayer(firstLayer(f));
			tries++;
			if ($unsigned(s[1]) > $unsigned(s[0]))
			begin
				applyAndCheck("classLane1", f);
				checkValue("classLane1", "classIdx", 1, classIdx);
				hits++;
			end
		end
		if (hits < 3)
		begin
			errorCount++;
			$display("Too few vectors with a larger score in lane 1 were found");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequence and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		reset = 1'b1;
		features = '0;
		resetClears();
		zeroFeatureVector();
		oneHotFeatures();
		negativeHiddenSums();
		streamVectors();
		classTieBreak();
		$display("Errors: %0d from checks, %0d from assertions", errorCount,
			i_netTop.i_netTopChk.failCount);
		if (errorCount == 0 && i_netTop.i_netTopChk.failCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		#(TimeoutNs);
		$display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
rtl/net_pkg.sv
rtl/neuronNode.sv
rtl/classSelect.sv
rtl/netTop.sv
tb/netTop_chk.sv
tb/tb_netTop.sv
